// File: dcache_tag_array.f
design/dcache_pkg.sv
design/dcache_tag_ctrl.sv
design/tag_way.sv
design/tag_hit_resolve.sv
design/dcache_tag_array.sv
sim/dcache_tag_array_assertions.sv
sim/dcache_tag_array_tb.sv

// File: sim/dcache_tag_array_trace.txt
# grp lookup_valid lookup_index lookup_tag update_valid update_op update_index update_way update_tag
# expect hit hit_way multi_hit victim_way   (hex; op 0 none, 1 fill, 2 invalidate, 3 clear)
1 1 0 0000123 0 0 0 0 0000000 1 0 0 0 0
1 1 5 1abcdef 0 0 0 0 0000000 1 0 0 0 0
1 1 f 0000000 0 0 0 0 0000000 1 0 0 0 0
2 0 0 0000000 1 1 3 1 00aaaaa 0 0 0 0 0
2 1 3 00aaaaa 0 0 0 0 0000000 1 1 1 0 0
2 1 3 00bbbbb 0 0 0 0 0000000 1 0 0 0 0
3 1 7 0123456 1 1 7 0 0123456 1 1 0 0 1
3 1 7 0123456 1 2 7 0 0000000 1 0 0 0 0
3 1 7 0777777 1 1 7 1 0777777 1 1 1 0 0
3 1 7 0777777 1 3 7 1 1ffffff 1 0 0 0 0
3 1 7 0777777 1 1 8 1 0777777 1 0 0 0 0
4 0 0 0000000 1 1 9 0 0000900 0 0 0 0 0
4 0 0 0000000 1 1 9 1 0000901 0 0 0 0 0
4 1 9 0000900 0 0 0 0 0000000 1 1 0 0 0
4 1 9 0000901 0 0 0 0 0000000 1 1 1 0 1
4 1 9 0000901 0 0 0 0 0000000 1 1 1 0 0
4 1 9 0000abc 0 0 0 0 0000000 1 0 0 0 0
4 0 0 0000000 1 1 9 0 0000abc 0 0 0 0 0
4 1 9 0000abc 0 0 0 0 0000000 1 1 0 0 1
5 0 0 0000000 1 2 9 0 0000000 0 0 0 0 0
5 1 9 0000abc 0 0 0 0 0000000 1 0 0 0 0
5 1 9 0000901 0 0 0 0 0000000 1 1 1 0 0
5 0 0 0000000 1 3 9 1 0000000 0 0 0 0 0
5 1 9 0000000 0 0 0 0 0000000 1 0 0 0 0
5 0 0 0000000 1 3 a 0 0000000 0 0 0 0 0
5 0 0 0000000 1 3 a 1 0000000 0 0 0 0 0
5 1 a 0000000 0 0 0 0 0000000 1 0 0 0 0
6 0 0 0000000 1 1 c 0 0ccccc0 0 0 0 0 0
6 0 0 0000000 1 1 c 1 0ccccc0 0 0 0 0 0
6 1 c 0ccccc0 0 0 0 0 0000000 1 1 0 1 0
6 1 c 0ccccc0 0 0 0 0 0000000 1 1 0 1 1

// File: sim/dcache_tag_array_tb.sv
`timescale 1ns/1ps

module dcache_tag_array_tb;

    import dcache_pkg::*;

    logic                   clk;
    logic                   reset;
    logic                   lookup_valid;
    logic [INDEX_WIDTH-1:0] lookup_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;
    logic                   update_valid;
    update_op_t             update_op;
    logic [INDEX_WIDTH-1:0] update_index;
    logic [WAY_WIDTH-1:0]   update_way;
    logic [TAG_WIDTH-1:0]   update_tag;
    logic                   lookup_done;
    logic                   hit;
    logic [WAY_WIDTH-1:0]   hit_way;
    logic                   multi_hit;
    logic [WAY_WIDTH-1:0]   victim_way;

    int error_count;
    int check_count;
    int group_first_error;
    int group_first_check;
    int groups_passed;
    int groups_failed;

    dcache_tag_array uut (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .update_valid (update_valid),
        .update_op    (update_op),
        .update_index (update_index),
        .update_way   (update_way),
        .update_tag   (update_tag),
        .lookup_done  (lookup_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .multi_hit    (multi_hit),
        .victim_way   (victim_way)
    );

    bind dcache_tag_array dcache_tag_array_assertions checks (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_done  (lookup_done),
        .hit          (hit),
        .multi_hit    (multi_hit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare and bookkeeping tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0b got %0b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_way(input string name, input logic [WAY_WIDTH-1:0] expected,
                             input logic [WAY_WIDTH-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Polls at the falling edge, gives up after 4 cycles
    task automatic wait_for_result(output bit seen, output int late);
        seen = 1'b0;
        late = 0;
        while (!seen && late < 4) begin
            @(negedge clk);
            if (lookup_done) begin
                seen = 1'b1;
            end else begin
                late++;
            end
        end
    endtask

    task automatic finish_group(input int group);
        if (error_count == group_first_error) begin
            groups_passed++;
            $display("Group %0d done, %0d checks ok", group, check_count - group_first_check);
        end else begin
            groups_failed++;
            $display("Group %0d done, %0d errors", group, error_count - group_first_error);
        end
        group_first_error = error_count;
        group_first_check = check_count;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Trace replay
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int          fd;
        int          fields;
        int          cur_group;
        int          late;
        bit          seen;
        string       line;
        logic [31:0] grp, lv, lidx, ltag, uv, op, uidx, uway, utag;
        logic [31:0] exp_flag, exp_hit, exp_way, exp_multi, exp_victim;

        reset        = 1'b1;
        lookup_valid = 1'b0;
        lookup_index = '0;
        lookup_tag   = '0;
        update_valid = 1'b0;
        update_op    = upd_none;
        update_index = '0;
        update_way   = '0;
        update_tag   = '0;
        error_count       = 0;
        check_count       = 0;
        group_first_error = 0;
        group_first_check = 0;
        groups_passed     = 0;
        groups_failed     = 0;
        cur_group         = -1;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("sim/dcache_tag_array_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 grp, lv, lidx, ltag, uv, op, uidx, uway, utag,
                                 exp_flag, exp_hit, exp_way, exp_multi, exp_victim);
                if (fields != 14) begin
                    $display("Trace line could not be parsed: %s", line);
                    error_count++;
                    continue;
                end
                if (int'(grp) != cur_group) begin
                    if (cur_group >= 0) begin
                        finish_group(cur_group);
                    end
                    cur_group = int'(grp);
                end

                // One cycle of both ports, then idle
                @(posedge clk);
                lookup_valid <= lv[0];
                lookup_index <= lidx[INDEX_WIDTH-1:0];
                lookup_tag   <= ltag[TAG_WIDTH-1:0];
                update_valid <= uv[0];
                update_op    <= update_op_t'(op[1:0]);
                update_index <= uidx[INDEX_WIDTH-1:0];
                update_way   <= uway[WAY_WIDTH-1:0];
                update_tag   <= utag[TAG_WIDTH-1:0];
                @(posedge clk);
                lookup_valid <= 1'b0;
                update_valid <= 1'b0;

                if (exp_flag[0]) begin
                    wait_for_result(seen, late);
                    if (!seen) begin
                        $display("Timeout at %0t: lookup_done never pulsed within 4 cycles",
                                 $time);
                        error_count++;
                    end else begin
                        if (late != 0) begin
                            $display("At %0t lookup_done came %0d cycles late", $time, late);
                            error_count++;
                        end
                        check_bit("hit", exp_hit[0], hit);
                        // hit_way only means something on a hit
                        if (exp_hit[0]) begin
                            check_way("hit_way", exp_way[WAY_WIDTH-1:0], hit_way);
                        end
                        check_bit("multi_hit", exp_multi[0], multi_hit);
                        check_way("victim_way", exp_victim[WAY_WIDTH-1:0], victim_way);
                        @(negedge clk);
                        if (lookup_done) begin
                            $display("At %0t lookup_done stayed high a second cycle", $time);
                            error_count++;
                        end
                    end
                end
            end
            $fclose(fd);
            if (cur_group >= 0) begin
                finish_group(cur_group);
            end
        end

        $display("Groups passed %0d, groups failed %0d, errors %0d, assertion failures %0d",
                 groups_passed, groups_failed, error_count, uut.checks.failures);
        if (error_count == 0 && uut.checks.failures == 0 && groups_passed > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sim/dcache_tag_array_assertions.sv
`timescale 1ns/1ps

module dcache_tag_array_assertions (
    input logic clk,
    input logic reset,
    input logic lookup_valid,
    input logic lookup_done,
    input logic hit,
    input logic multi_hit
);

    // Count of failed assertions
    int failures = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Result pulse timing
    ////////////////////////////////////////////////////////////////////////////

    // A request gives a pulse in the next cycle
    assert property (@(posedge clk) disable iff (reset) lookup_valid |=> lookup_done)
        else begin
            $error("lookup_done missing one cycle after lookup_valid");
            failures++;
        end

    // No request, no pulse
    assert property (@(posedge clk) disable iff (reset) !lookup_valid |=> !lookup_done)
        else begin
            $error("lookup_done high without a lookup in the previous cycle");
            failures++;
        end

    // Pipeline register cleared by reset
    assert property (@(posedge clk) reset |=> !lookup_done)
        else begin
            $error("lookup_done high after reset");
            failures++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Result consistency
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (reset) multi_hit |-> hit)
        else begin
            $error("multi_hit without hit");
            failures++;
        end

endmodule

// File: design/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                              clk,
    input  logic                              reset,

    // Lookup port
    input  logic                              lookup_valid,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] lookup_index,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   lookup_tag,

    // Update port
    input  logic                              update_valid,
    input  dcache_pkg::update_op_t            update_op,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] update_index,
    input  logic [dcache_pkg::WAY_WIDTH-1:0]   update_way,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   update_tag,

    // Lookup result, one cycle after the request
    output logic                              lookup_done,
    output logic                              hit,
    output logic [dcache_pkg::WAY_WIDTH-1:0]   hit_way,
    output logic                              multi_hit,
    output logic [dcache_pkg::WAY_WIDTH-1:0]   victim_way
);

    import dcache_pkg::*;

    logic [NUM_WAYS-1:0]    way_write;
    logic [NUM_WAYS-1:0]    way_set_valid;
    logic [NUM_WAYS-1:0]    way_clear_valid;
    logic [INDEX_WIDTH-1:0] write_index;
    logic [TAG_WIDTH-1:0]   write_tag;
    logic                   fill_strobe;
    logic [WAY_WIDTH-1:0]   fill_way;
    logic [NUM_WAYS-1:0]    way_hit;
    logic [NUM_WAYS-1:0]    way_valid;

    dcache_tag_ctrl ctrl (
        .update_valid    (update_valid),
        .update_op       (update_op),
        .update_index    (update_index),
        .update_way      (update_way),
        .update_tag      (update_tag),
        .way_write       (way_write),
        .way_set_valid   (way_set_valid),
        .way_clear_valid (way_clear_valid),
        .write_index     (write_index),
        .write_tag       (write_tag),
        .fill_strobe     (fill_strobe),
        .fill_way        (fill_way)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        tag_way way (
            .clk             (clk),
            .reset           (reset),
            .lookup_valid    (lookup_valid),
            .lookup_index    (lookup_index),
            .lookup_tag      (lookup_tag),
            .way_write       (way_write[i]),
            .way_set_valid   (way_set_valid[i]),
            .way_clear_valid (way_clear_valid[i]),
            .write_index     (write_index),
            .write_tag       (write_tag),
            .way_hit         (way_hit[i]),
            .way_valid       (way_valid[i])
        );
    end

    tag_hit_resolve resolve (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_index (lookup_index),
        .way_hit      (way_hit),
        .way_valid    (way_valid),
        .fill_strobe  (fill_strobe),
        .fill_way     (fill_way),
        .write_index  (write_index),
        .lookup_done  (lookup_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .multi_hit    (multi_hit),
        .victim_way   (victim_way)
    );

endmodule

// File: design/tag_hit_resolve.sv
`timescale 1ns/1ps

module tag_hit_resolve (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              lookup_valid,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] lookup_index,

    // From the ways, result cycle
    input  logic [dcache_pkg::NUM_WAYS-1:0]    way_hit,
    input  logic [dcache_pkg::NUM_WAYS-1:0]    way_valid,

    // From the control block
    input  logic                              fill_strobe,
    input  logic [dcache_pkg::WAY_WIDTH-1:0]   fill_way,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] write_index,

    output logic                              lookup_done,
    output logic                              hit,
    output logic [dcache_pkg::WAY_WIDTH-1:0]   hit_way,
    output logic                              multi_hit,
    output logic [dcache_pkg::WAY_WIDTH-1:0]   victim_way
);

    import dcache_pkg::*;

    logic [INDEX_WIDTH-1:0] index_q;

    // One bit per set, holds the most recently used way
    logic [NUM_SETS-1:0]    lru_bits;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_done <= 1'b0;
        end else begin
            lookup_done <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            index_q <= lookup_index;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hit reduction and victim
    ////////////////////////////////////////////////////////////////////////////

    assign hit       = lookup_done && (|way_hit);
    assign multi_hit = lookup_done && (&way_hit);

    // Lowest hitting way wins
    assign hit_way = way_hit[0] ? WAY_WIDTH'(0) : WAY_WIDTH'(1);

    // First invalid way, else the way not most recently used
    always_comb begin
        if (!way_valid[0]) begin
            victim_way = WAY_WIDTH'(0);
        end else if (!way_valid[1]) begin
            victim_way = WAY_WIDTH'(1);
        end else begin
            victim_way = WAY_WIDTH'(!lru_bits[index_q]);
        end
    end

    // Fill is applied last so it wins on the same set
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else begin
            if (hit) begin
                lru_bits[index_q] <= hit_way;
            end
            if (fill_strobe) begin
                lru_bits[write_index] <= fill_way;
            end
        end
    end

endmodule

// File: design/tag_way.sv
`timescale 1ns/1ps

module tag_way (
    input  logic                              clk,
    input  logic                              reset,

    // Lookup port
    input  logic                              lookup_valid,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] lookup_index,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   lookup_tag,

    // Write side for this way
    input  logic                              way_write,
    input  logic                              way_set_valid,
    input  logic                              way_clear_valid,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] write_index,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   write_tag,

    // Result cycle outputs
    output logic                              way_hit,
    output logic                              way_valid
);

    import dcache_pkg::*;

    logic [TAG_WIDTH-1:0] tag_ram [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_bits;

    logic                 same_set;
    logic                 valid_next;
    logic                 tag_fwd;

    logic [TAG_WIDTH-1:0] tag_q;
    logic [TAG_WIDTH-1:0] cmp_tag_q;
    logic                 valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (way_write) begin
            tag_ram[write_index] <= write_tag;
        end
    end

    // Invalidate and clear take priority over set
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (way_clear_valid) begin
            valid_bits[write_index] <= 1'b0;
        end else if (way_set_valid) begin
            valid_bits[write_index] <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-during-write forwarding
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        same_set   = (write_index == lookup_index);
        valid_next = valid_bits[lookup_index];
        if (same_set && way_clear_valid) begin
            valid_next = 1'b0;
        end else if (same_set && way_set_valid) begin
            valid_next = 1'b1;
        end
        tag_fwd = same_set && way_write;
    end

    // Synchronous tag read, lookup tag held for the compare
    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            tag_q     <= tag_fwd ? write_tag : tag_ram[lookup_index];
            cmp_tag_q <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (lookup_valid) begin
            valid_q <= valid_next;
        end
    end

    // Compare in the result cycle
    assign way_valid = valid_q;
    assign way_hit   = valid_q && (tag_q == cmp_tag_q);

endmodule

// File: design/dcache_tag_ctrl.sv
`timescale 1ns/1ps

module dcache_tag_ctrl (
    // Update port
    input  logic                              update_valid,
    input  dcache_pkg::update_op_t            update_op,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] update_index,
    input  logic [dcache_pkg::WAY_WIDTH-1:0]   update_way,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   update_tag,

    // Per-way strobes
    output logic [dcache_pkg::NUM_WAYS-1:0]    way_write,
    output logic [dcache_pkg::NUM_WAYS-1:0]    way_set_valid,
    output logic [dcache_pkg::NUM_WAYS-1:0]    way_clear_valid,

    // Shared write data
    output logic [dcache_pkg::INDEX_WIDTH-1:0] write_index,
    output logic [dcache_pkg::TAG_WIDTH-1:0]   write_tag,

    // Fill notice for the LRU bits
    output logic                              fill_strobe,
    output logic [dcache_pkg::WAY_WIDTH-1:0]   fill_way
);

    import dcache_pkg::*;

    logic [NUM_WAYS-1:0] way_sel;

    // One-hot select of the addressed way
    assign way_sel = NUM_WAYS'(1) << update_way;

    assign write_index = update_index;
    assign fill_way    = update_way;

    ////////////////////////////////////////////////////////////////////////////
    // Op decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        way_write       = '0;
        way_set_valid   = '0;
        way_clear_valid = '0;
        fill_strobe     = 1'b0;

        // Init sweep writes a zero tag
        if (update_op == upd_clear) begin
            write_tag = '0;
        end else begin
            write_tag = update_tag;
        end

        if (update_valid) begin
            case (update_op)
                upd_fill: begin
                    way_write     = way_sel;
                    way_set_valid = way_sel;
                    fill_strobe   = 1'b1;
                end
                upd_invalidate: begin
                    // Tag left as is
                    way_clear_valid = way_sel;
                end
                upd_clear: begin
                    way_write       = way_sel;
                    way_clear_valid = way_sel;
                end
                default: begin
                    // upd_none
                end
            endcase
        end
    end

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////////////////////

    // Set index, 16 sets
    localparam int INDEX_WIDTH = 4;

    // Entries per way, one per set
    localparam int NUM_SETS = 1 << INDEX_WIDTH;

    // Stored tag, upper address bits above index and line offset
    localparam int TAG_WIDTH = 25;

    // Two-way set associative
    localparam int NUM_WAYS = 2;

    // Way number width
    localparam int WAY_WIDTH = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Update port operations
    ////////////////////////////////////////////////////////////////////////////

    // Encodings are fixed since the trace carries the op as a number
    //   none       no effect
    //   fill       write tag, set valid
    //   invalidate clear valid only, tag kept
    //   clear      zero tag and valid, init sweep
    typedef enum logic [1:0] {
        upd_none       = 2'd0,
        upd_fill       = 2'd1,
        upd_invalidate = 2'd2,
        upd_clear      = 2'd3
    } update_op_t;

endpackage
